/* sim/vlsu_testdata.txt */
# D cmt_id is_store vreg base vl sew(0 byte 1 half 2 word) gap | B bank_mask hold_cycles
# R vreg elem expected_hex, checked once all earlier instructions are done
D 0 0 1 0 4 2 2
D 1 0 2 17 4 0 2
D 2 0 3 32 4 1 2
D 3 0 4 66 2 1 2
D 4 0 5 200 3 0 2
D 5 1 1 128 4 2 4
D 6 1 3 150 4 0 4
D 7 1 1 96 4 1 4
D 8 0 6 128 4 2 2
D 9 0 7 150 4 0 2
D 10 0 0 96 4 1 2
R 6 3 0f0e0d0c
R 7 1 00000022
R 0 2 00000908
R 2 0 00000011
B 2 30
D 11 0 1 64 4 2 0
D 12 0 2 84 4 1 0
D 13 0 3 20 4 0 0
R 1 1 47464544
R 3 3 00000017
B 1 12
D 14 0 4 0 4 2 0
D 15 0 5 240 4 0 0
D 16 0 6 44 2 2 0
R 5 2 000000f2
R 4 0 03020100
R 6 1 33323130

/* sim.f */
hdl/vlsu_pkg.sv
hdl/vlsu_issue_queue.sv
hdl/vlsu_uop_gen.sv
hdl/vlsu_replay_queue.sv
hdl/vlsu_pipe.sv
hdl/vlsu_top.sv
sim/vlsu_tb.sv

/* Bender.yml */
package:
  name: vlsu

sources:
  - files:
      - hdl/vlsu_pkg.sv
      - hdl/vlsu_issue_queue.sv
      - hdl/vlsu_uop_gen.sv
      - hdl/vlsu_replay_queue.sv
      - hdl/vlsu_pipe.sv
      - hdl/vlsu_top.sv
  - target: simulation
    files:
      - sim/vlsu_tb.sv

/* sim/vlsu_tb.sv */
`timescale 1ns/100ps

module vlsu_tb;

   import vlsu_pkg::*;

   localparam int IQ_DEPTH  = 4;
   localparam int RQ_DEPTH  = 4;
   localparam int NUM_BANKS = 4;

   // Expected register write, matched by vreg and element
   typedef struct packed {
      logic [4:0]  id;
      logic [2:0]  vreg;
      logic [1:0]  elem;
      logic [31:0] data;
   } exp_wr_t;

   logic                 i_clk;
   logic                 i_rst;
   logic                 i_disp_valid;
   disp_t                i_disp;
   logic [NUM_BANKS-1:0] i_bank_busy;
   logic                 o_iq_full;
   vrf_wr_t              o_vrf_wr;
   done_rpt_t            o_done;

   logic [7:0]  ref_mem [256];
   logic [31:0] ref_vrf [8][4];
   logic [31:0] obs_vrf [8][4];
   exp_wr_t     exp_q [$];
   int          wr_left [32];
   bit          disp_seen [32];
   bit          done_seen [32];
   int          n_disp;
   int          n_done;
   int          n_records;
   int          busy_left;
   logic [31:0] rng_state;

   vlsu_top #(
      .IQ_DEPTH  (IQ_DEPTH),
      .RQ_DEPTH  (RQ_DEPTH),
      .NUM_BANKS (NUM_BANKS)
   ) dut (
      .i_clk        (i_clk),
      .i_rst        (i_rst),
      .i_disp_valid (i_disp_valid),
      .i_disp       (i_disp),
      .i_bank_busy  (i_bank_busy),
      .o_iq_full    (o_iq_full),
      .o_vrf_wr     (o_vrf_wr),
      .o_done       (o_done)
   );

   always #4 i_clk = ~i_clk;

   // --------------------
   // Reporting
   // --------------------
   task automatic stop_run(input string why);
      if (why.len() > 0) begin
         $display("%s", why);
      end
      $display("Result: FAILED");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
         stop_run("");
      end
   endtask

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] r;
      r = x ^ (x << 13);
      r = r ^ (r >> 17);
      r = r ^ (r << 5);
      return r;
   endfunction

   // --------------------
   // Reference model
   // --------------------
   task automatic model_dispatch(input disp_t d);
      int          nbytes;
      logic [7:0]  a;
      logic [31:0] data;
      exp_wr_t     ent;
      nbytes = 1 << d.sew;
      for (int e = 0; e < d.vl; e++) begin
         a = d.base + 8'(e * nbytes);   // Unit stride
         if (d.is_store) begin
            for (int b = 0; b < nbytes; b++) begin
               ref_mem[8'(a + b)] = ref_vrf[d.vreg][e][8*b +: 8];
            end
         end else begin
            data = '0;
            for (int b = 0; b < nbytes; b++) begin
               data[8*b +: 8] = ref_mem[8'(a + b)];   // Little endian, zero-extended
            end
            ref_vrf[d.vreg][e] = data;
            ent.id   = d.cmt_id;
            ent.vreg = d.vreg;
            ent.elem = 2'(e);
            ent.data = data;
            exp_q.push_back(ent);
            wr_left[d.cmt_id]++;
         end
      end
   endtask

   // --------------------
   // Output monitor
   // --------------------
   task automatic take_vrf_write(input vrf_wr_t wr);
      int      idx;
      exp_wr_t ent;
      idx = -1;
      for (int i = 0; i < exp_q.size(); i++) begin
         if (idx < 0 && exp_q[i].vreg == wr.vreg && exp_q[i].elem == wr.elem) begin
            idx = i;
         end
      end
      if (idx < 0) begin
         stop_run($sformatf("unexpected register write to v%0d element %0d at %0t ns",
                            wr.vreg, wr.elem, $time));
      end else begin
         ent = exp_q[idx];
         check_value($sformatf("o_vrf_wr.data v%0d[%0d]", wr.vreg, wr.elem), wr.data, ent.data);
         obs_vrf[wr.vreg][wr.elem] = wr.data;
         wr_left[ent.id]--;
         exp_q.delete(idx);
      end
   endtask

   task automatic take_done(input cmt_id_t id);
      if (!disp_seen[id]) begin
         stop_run($sformatf("done reported for id %0d, which was never dispatched", id));
      end else if (done_seen[id]) begin
         stop_run($sformatf("second done reported for id %0d", id));
      end else if (wr_left[id] != 0) begin
         stop_run($sformatf("done for id %0d came before all of its register writes", id));
      end else begin
         done_seen[id] = 1'b1;
         n_done++;
      end
   endtask

   // Sampled mid-cycle, writes before done
   always @(negedge i_clk) begin
      if (!i_rst) begin
         if (o_vrf_wr.valid) begin
            take_vrf_write(o_vrf_wr);
         end
         if (o_done.valid) begin
            take_done(o_done.cmt_id);
         end
      end
   end

   // --------------------
   // Stimulus
   // --------------------
   task automatic next_cycle();
      @(posedge i_clk);
      #1;
      if (busy_left > 0) begin
         busy_left--;
         if (busy_left == 0) begin
            i_bank_busy = '0;   // Bank hold expired
         end
      end
   endtask

   task automatic drain();
      while (n_done != n_disp) begin
         next_cycle();
      end
   endtask

   task automatic dispatch(input disp_t d, input int gap);
      int extra;
      while (o_iq_full) begin
         next_cycle();
      end
      i_disp       = d;
      i_disp_valid = 1'b1;
      model_dispatch(d);
      disp_seen[d.cmt_id] = 1'b1;
      n_disp++;
      next_cycle();
      i_disp_valid = 1'b0;
      repeat (gap) next_cycle();
      if (!o_iq_full) begin
         rng_state = xorshift32(rng_state);
         extra     = int'(rng_state % 4);
         repeat (extra) next_cycle();
      end
   endtask

   task automatic run_record(input int fd, input logic [8*16-1:0] tok);
      int          n;
      int          f_id, f_st, f_vreg, f_base, f_vl, f_sew, f_gap;
      int          f_mask, f_hold;
      logic [31:0] f_data;
      disp_t       d;
      logic [8*128-1:0] rest;
      if (tok == "D") begin
         n = $fscanf(fd, "%d %d %d %d %d %d %d", f_id, f_st, f_vreg, f_base, f_vl, f_sew,
                     f_gap);
         if (n != 7) begin
            stop_run("malformed D record in the test data");
         end else begin
            d          = '0;
            d.cmt_id   = 5'(f_id);
            d.is_store = f_st[0];
            d.vreg     = 3'(f_vreg);
            d.base     = 8'(f_base);
            d.vl       = 3'(f_vl);
            d.sew      = sew_t'(f_sew[1:0]);
            dispatch(d, f_gap);
         end
      end else if (tok == "B") begin
         n = $fscanf(fd, "%d %d", f_mask, f_hold);
         if (n != 2) begin
            stop_run("malformed B record in the test data");
         end else begin
            i_bank_busy = NUM_BANKS'(f_mask);
            busy_left   = f_hold;
         end
      end else if (tok == "R") begin
         n = $fscanf(fd, "%d %d %h", f_vreg, f_base, f_data);
         if (n != 3) begin
            stop_run("malformed R record in the test data");
         end else begin
            drain();
            check_value($sformatf("v%0d[%0d]", f_vreg, f_base), obs_vrf[f_vreg][f_base],
                        f_data);
         end
      end else begin
         n = $fgets(rest, fd);   // Comment line
      end
   endtask

   // Allowance grows with the length of the test data
   initial begin
      wait (n_records > 0);
      repeat (n_records * 200) @(posedge i_clk);
      stop_run("watchdog expired: the run did not finish in time");
   end

   initial begin
      int               fd;
      int               n;
      logic [8*16-1:0]  tok;
      logic [8*128-1:0] rest;
      i_clk        = 1'b0;
      i_rst        = 1'b1;
      i_disp_valid = 1'b0;
      i_disp       = '0;
      i_bank_busy  = '0;
      n_disp       = 0;
      n_done       = 0;
      n_records    = 0;
      busy_left    = 0;
      rng_state    = 32'd58787;
      for (int i = 0; i < 256; i++) begin
         ref_mem[i] = 8'(i);   // Same fill as the DUT after reset
      end
      for (int v = 0; v < 8; v++) begin
         for (int e = 0; e < 4; e++) begin
            ref_vrf[v][e] = '0;
            obs_vrf[v][e] = '0;
         end
      end
      for (int i = 0; i < 32; i++) begin
         wr_left[i]   = 0;
         disp_seen[i] = 1'b0;
         done_seen[i] = 1'b0;
      end

      fd = $fopen("sim/vlsu_testdata.txt", "r");
      if (fd == 0) begin
         stop_run("cannot open sim/vlsu_testdata.txt");
      end
      while ($fscanf(fd, "%s", tok) == 1) begin
         if (tok != "#") begin
            n_records++;
         end
         n = $fgets(rest, fd);
      end
      $fclose(fd);
      fd = $fopen("sim/vlsu_testdata.txt", "r");

      repeat (5) @(posedge i_clk);
      #1;
      i_rst = 1'b0;

      while ($fscanf(fd, "%s", tok) == 1) begin
         run_record(fd, tok);
      end
      $fclose(fd);
      drain();

      if (exp_q.size() != 0) begin
         stop_run($sformatf("missing register write: v%0d element %0d of id %0d never arrived",
                            exp_q[0].vreg, exp_q[0].elem, exp_q[0].id));
      end else begin
         check_value("o_iq_full", 32'(o_iq_full), 32'd0);
         $display("Result: PASSED");
         $finish;
      end
   end

endmodule

/* hdl/vlsu_top.sv */
`timescale 1ns/100ps

module vlsu_top #(
   parameter int IQ_DEPTH  = 4,
   parameter int RQ_DEPTH  = 4,
   parameter int NUM_BANKS = 4
) (
   input  logic                 i_clk,
   input  logic                 i_rst,
   input  logic                 i_disp_valid,
   input  vlsu_pkg::disp_t      i_disp,
   input  logic [NUM_BANKS-1:0] i_bank_busy,
   output logic                 o_iq_full,
   output vlsu_pkg::vrf_wr_t    o_vrf_wr,
   output vlsu_pkg::done_rpt_t  o_done
);

   import vlsu_pkg::*;

   logic  iq_head_valid;
   disp_t iq_head;
   logic  gen_take;
   logic  gen_valid;
   uop_t  gen_uop;
   logic  rq_valid;
   uop_t  rq_uop;
   logic  rq_full;
   logic  rp_push;
   uop_t  rp_uop;
   logic  sel_replay;
   logic  pipe_valid;
   uop_t  pipe_uop;

   vlsu_issue_queue #(.IQ_DEPTH(IQ_DEPTH)) u_issue_queue (
      .i_clk        (i_clk),
      .i_rst        (i_rst),
      .i_disp_valid (i_disp_valid),
      .i_disp       (i_disp),
      .i_pop        (gen_take),
      .o_head_valid (iq_head_valid),
      .o_head       (iq_head),
      .o_full       (o_iq_full)
   );

   vlsu_uop_gen u_uop_gen (
      .i_clk        (i_clk),
      .i_rst        (i_rst),
      .i_head_valid (iq_head_valid),
      .i_head       (iq_head),
      .i_stall      (sel_replay),
      .o_take       (gen_take),
      .o_uop_valid  (gen_valid),
      .o_uop        (gen_uop)
   );

   // --------------------
   // Replay vs new issue
   // --------------------
   // Full queue always wins, else the older uop goes first
   assign sel_replay = rq_full ||
                       (rq_valid && (!gen_valid || id_older(rq_uop.cmt_id, gen_uop.cmt_id)));
   assign pipe_valid = sel_replay ? rq_valid : gen_valid;
   assign pipe_uop   = sel_replay ? rq_uop : gen_uop;

   vlsu_replay_queue #(.RQ_DEPTH(RQ_DEPTH), .NUM_BANKS(NUM_BANKS)) u_replay_queue (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_push      (rp_push),
      .i_push_uop  (rp_uop),
      .i_bank_busy (i_bank_busy),
      .i_pick      (sel_replay),
      .o_valid     (rq_valid),
      .o_uop       (rq_uop),
      .o_full      (rq_full)
   );

   vlsu_pipe #(.NUM_BANKS(NUM_BANKS)) u_pipe (
      .i_clk         (i_clk),
      .i_rst         (i_rst),
      .i_uop_valid   (pipe_valid),
      .i_uop         (pipe_uop),
      .i_bank_busy   (i_bank_busy),
      .o_replay_push (rp_push),
      .o_replay_uop  (rp_uop),
      .o_vrf_wr      (o_vrf_wr),
      .o_done        (o_done)
   );

endmodule

/* hdl/vlsu_pipe.sv */
`timescale 1ns/100ps

module vlsu_pipe #(
   parameter int NUM_BANKS = 4
) (
   input  logic                 i_clk,
   input  logic                 i_rst,
   input  logic                 i_uop_valid,
   input  vlsu_pkg::uop_t       i_uop,
   input  logic [NUM_BANKS-1:0] i_bank_busy,
   output logic                 o_replay_push,
   output vlsu_pkg::uop_t       o_replay_uop,
   output vlsu_pkg::vrf_wr_t    o_vrf_wr,
   output vlsu_pkg::done_rpt_t  o_done
);

   import vlsu_pkg::*;

   logic        r_ex1_valid;
   uop_t        r_ex1_uop;
   logic        w_ex1_conflict;
   logic        r_ex2_valid;
   uop_t        r_ex2_uop;

   logic [31:0] r_vrf [8][4];
   logic [31:0] r_mem [64];
   logic [2:0]  r_done_cnt [16];

   elem_word_u  w_mem_word;
   elem_word_u  w_st_word;
   logic [31:0] w_ld_data;
   logic [31:0] w_st_src;
   logic [5:0]  w_word_idx;
   logic [3:0]  w_pos;
   logic        w_last;

   // --------------------
   // ex1
   // --------------------
   assign w_ex1_conflict = r_ex1_valid && i_bank_busy[r_ex1_uop.addr[7:2] % NUM_BANKS];
   assign o_replay_push  = w_ex1_conflict;   // Back to the replay queue
   assign o_replay_uop   = r_ex1_uop;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         r_ex1_valid <= 1'b0;
         r_ex2_valid <= 1'b0;
      end else begin
         r_ex1_valid <= i_uop_valid;
         r_ex2_valid <= r_ex1_valid && !w_ex1_conflict;
      end
   end

   always_ff @(posedge i_clk) begin
      r_ex1_uop <= i_uop;
      r_ex2_uop <= r_ex1_uop;
   end

   // --------------------
   // ex2
   // --------------------
   assign w_word_idx = r_ex2_uop.addr[7:2];
   assign w_mem_word = r_mem[w_word_idx];
   assign w_ld_data  = lane_extract(w_mem_word, r_ex2_uop.addr[1:0], r_ex2_uop.sew);
   assign w_st_src   = r_vrf[r_ex2_uop.vreg][r_ex2_uop.elem];
   assign w_st_word  = lane_merge(w_mem_word, r_ex2_uop.addr[1:0], r_ex2_uop.sew, w_st_src);

   // Register file and backing memory
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         for (int v = 0; v < 8; v++) begin
            for (int e = 0; e < 4; e++) begin
               r_vrf[v][e] <= '0;
            end
         end
         for (int i = 0; i < 64; i++) begin
            for (int j = 0; j < 4; j++) begin
               r_mem[i][j*8 +: 8] <= 8'(i * 4 + j);   // Byte holds its own address
            end
         end
      end else if (r_ex2_valid) begin
         if (r_ex2_uop.is_store) begin
            r_mem[w_word_idx] <= w_st_word.w;
         end else begin
            r_vrf[r_ex2_uop.vreg][r_ex2_uop.elem] <= w_ld_data;
         end
      end
   end

   assign o_vrf_wr.valid = r_ex2_valid && !r_ex2_uop.is_store;
   assign o_vrf_wr.vreg  = r_ex2_uop.vreg;
   assign o_vrf_wr.elem  = r_ex2_uop.elem;
   assign o_vrf_wr.data  = w_ld_data;

   // --------------------
   // Done tracking
   // --------------------
   assign w_pos  = r_ex2_uop.cmt_id[3:0];
   assign w_last = ((r_done_cnt[w_pos] + 3'd1) == r_ex2_uop.vl);

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         for (int i = 0; i < 16; i++) begin
            r_done_cnt[i] <= '0;
         end
      end else if (r_ex2_valid) begin
         r_done_cnt[w_pos] <= w_last ? 3'd0 : r_done_cnt[w_pos] + 3'd1;
      end
   end

   assign o_done.valid  = r_ex2_valid && w_last;   // Same cycle as last element
   assign o_done.cmt_id = r_ex2_uop.cmt_id;

endmodule

/* hdl/vlsu_replay_queue.sv */
`timescale 1ns/100ps

module vlsu_replay_queue #(
   parameter int RQ_DEPTH  = 4,
   parameter int NUM_BANKS = 4
) (
   input  logic                 i_clk,
   input  logic                 i_rst,
   input  logic                 i_push,
   input  vlsu_pkg::uop_t       i_push_uop,
   input  logic [NUM_BANKS-1:0] i_bank_busy,
   input  logic                 i_pick,
   output logic                 o_valid,
   output vlsu_pkg::uop_t       o_uop,
   output logic                 o_full
);

   import vlsu_pkg::*;

   localparam int RW = $clog2(RQ_DEPTH);
   localparam int CW = $clog2(RQ_DEPTH + 1);

   logic [RQ_DEPTH-1:0] r_valid;
   uop_t                r_uop [RQ_DEPTH];
   logic [RQ_DEPTH-1:0] w_ready;
   logic [RW-1:0]       w_free_idx;
   logic [RW-1:0]       w_sel_idx;
   logic [CW-1:0]       w_count;

   // --------------------
   // Slot search
   // --------------------
   always_comb begin
      w_free_idx = '0;
      w_count    = '0;
      for (int i = RQ_DEPTH - 1; i >= 0; i--) begin
         if (!r_valid[i]) begin
            w_free_idx = RW'(i);   // Lowest free slot wins
         end
         w_count = w_count + CW'(r_valid[i]);
      end
   end

   // Oldest entry whose bank is free
   always_comb begin
      o_valid   = 1'b0;
      w_sel_idx = '0;
      for (int i = 0; i < RQ_DEPTH; i++) begin
         w_ready[i] = r_valid[i] && !i_bank_busy[r_uop[i].addr[7:2] % NUM_BANKS];
         if (w_ready[i] && (!o_valid || id_older(r_uop[i].cmt_id, r_uop[w_sel_idx].cmt_id))) begin
            o_valid   = 1'b1;
            w_sel_idx = RW'(i);
         end
      end
   end

   assign o_uop  = r_uop[w_sel_idx];
   // One slot held back for the uop already in ex1
   assign o_full = (w_count >= CW'(RQ_DEPTH - 1));

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         r_valid <= '0;
      end else begin
         if (i_pick && o_valid) begin
            r_valid[w_sel_idx] <= 1'b0;
         end
         if (i_push) begin
            r_valid[w_free_idx] <= 1'b1;   // Never the picked slot, that one is valid
         end
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_push) begin
         r_uop[w_free_idx] <= i_push_uop;
      end
   end

   a_no_push_when_full : assert property (
      @(posedge i_clk) disable iff (i_rst)
      i_push |-> !(&r_valid)
   ) else $error("replay queue: push with no free slot");

endmodule

/* hdl/vlsu_uop_gen.sv */
`timescale 1ns/100ps

module vlsu_uop_gen (
   input  logic            i_clk,
   input  logic            i_rst,
   input  logic            i_head_valid,
   input  vlsu_pkg::disp_t i_head,
   input  logic            i_stall,
   output logic            o_take,
   output logic            o_uop_valid,
   output vlsu_pkg::uop_t  o_uop
);

   import vlsu_pkg::*;

   logic       r_busy;
   disp_t      r_inst;
   logic [1:0] r_elem;
   logic       w_last;
   logic       w_step;

   // Latch only when idle and new issue is granted
   assign o_take = i_head_valid && !r_busy && !i_stall;
   assign w_step = r_busy && !i_stall;   // Current element goes to the pipe
   assign w_last = ({1'b0, r_elem} == (r_inst.vl - 3'd1));

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         r_busy <= 1'b0;
         r_elem <= '0;
      end else if (o_take) begin
         r_busy <= 1'b1;
         r_elem <= '0;
      end else if (w_step) begin
         if (w_last) begin
            r_busy <= 1'b0;
         end
         r_elem <= r_elem + 1'b1;
      end
   end

   always_ff @(posedge i_clk) begin
      if (o_take) begin
         r_inst <= i_head;
      end
   end

   // --------------------
   // Element uop
   // --------------------
   assign o_uop_valid = r_busy;

   always_comb begin
      o_uop.cmt_id   = r_inst.cmt_id;
      o_uop.is_store = r_inst.is_store;
      o_uop.vreg     = r_inst.vreg;
      o_uop.elem     = r_elem;
      o_uop.addr     = r_inst.base + (8'(r_elem) << r_inst.sew);   // Index scaled by sew
      o_uop.sew      = r_inst.sew;
      o_uop.vl       = r_inst.vl;
   end

   // A vl outside 1 to 4 would never reach the last element
   a_legal_shape : assert property (
      @(posedge i_clk) disable iff (i_rst)
      o_take |-> ((i_head.vl != 3'd0) && (i_head.vl <= 3'd4) &&
                  (i_head.sew inside {SEW_B, SEW_H, SEW_W}))
   ) else $error("uop gen: issued instruction with illegal vl or sew");

endmodule

/* hdl/vlsu_issue_queue.sv */
`timescale 1ns/100ps

module vlsu_issue_queue #(
   parameter int IQ_DEPTH = 4
) (
   input  logic            i_clk,
   input  logic            i_rst,
   input  logic            i_disp_valid,
   input  vlsu_pkg::disp_t i_disp,
   input  logic            i_pop,
   output logic            o_head_valid,
   output vlsu_pkg::disp_t o_head,
   output logic            o_full
);

   import vlsu_pkg::*;

   localparam int PW = $clog2(IQ_DEPTH);
   localparam int CW = $clog2(IQ_DEPTH + 1);

   disp_t          r_entry [IQ_DEPTH];
   logic [PW-1:0]  r_wr_ptr;
   logic [PW-1:0]  r_rd_ptr;
   logic [CW-1:0]  r_count;
   logic           w_push;
   logic           w_pop;

   // Program order in, so the head is always the oldest
   assign w_push = i_disp_valid && !o_full;
   assign w_pop  = i_pop && (r_count != '0);

   assign o_full       = (r_count == CW'(IQ_DEPTH));
   assign o_head_valid = (r_count != '0);
   assign o_head       = r_entry[r_rd_ptr];

   // --------------------
   // Pointers and count
   // --------------------
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         r_wr_ptr <= '0;
         r_rd_ptr <= '0;
         r_count  <= '0;
      end else begin
         if (w_push) begin
            r_wr_ptr <= (r_wr_ptr == PW'(IQ_DEPTH - 1)) ? '0 : r_wr_ptr + 1'b1;
         end
         if (w_pop) begin
            r_rd_ptr <= (r_rd_ptr == PW'(IQ_DEPTH - 1)) ? '0 : r_rd_ptr + 1'b1;
         end
         case ({w_push, w_pop})
            2'b10:   r_count <= r_count + 1'b1;
            2'b01:   r_count <= r_count - 1'b1;
            default: r_count <= r_count;   // Push and pop cancel
         endcase
      end
   end

   // Payload storage
   always_ff @(posedge i_clk) begin
      if (w_push) begin
         r_entry[r_wr_ptr] <= i_disp;
      end
   end

   // --------------------
   // Checks
   // --------------------
   // Dispatcher must watch o_full
   a_no_disp_when_full : assert property (
      @(posedge i_clk) disable iff (i_rst)
      i_disp_valid |-> !o_full
   ) else $error("issue queue: dispatch while full");

endmodule

/* hdl/vlsu_pkg.sv */
package vlsu_pkg;

   // --------------------
   // Commit id and age
   // --------------------
   typedef logic [4:0] cmt_id_t;   // [4] wrap flag, [3:0] position

   // True when a is older than b
   function automatic logic id_older(cmt_id_t a, cmt_id_t b);
      if (a[4] == b[4]) begin
         return a[3:0] < b[3:0];
      end
      return a[3:0] > b[3:0];   // Opposite wrap, b has already wrapped
   endfunction

   typedef enum logic [1:0] {
      SEW_B = 2'd0,
      SEW_H = 2'd1,
      SEW_W = 2'd2
   } sew_t;

   // --------------------
   // Instruction and uop
   // --------------------
   typedef struct packed {
      logic [3:0] pad;
      cmt_id_t    cmt_id;
      logic       is_store;
      logic [2:0] vreg;       // Load destination or store source
      logic [7:0] base;       // Byte address
      logic [2:0] vl;         // 1 to 4
      sew_t       sew;
   } disp_t;

   typedef struct packed {
      cmt_id_t    cmt_id;
      logic       is_store;
      logic [2:0] vreg;
      logic [1:0] elem;
      logic [7:0] addr;
      sew_t       sew;
      logic [2:0] vl;         // Element count for done tracking
   } uop_t;

   // One data word seen as word, bytes or halves
   typedef union packed {
      logic [31:0]      w;
      logic [3:0][7:0]  b;
      logic [1:0][15:0] h;
   } elem_word_u;

   typedef struct packed {
      logic        valid;
      logic [2:0]  vreg;
      logic [1:0]  elem;
      logic [31:0] data;
   } vrf_wr_t;

   typedef struct packed {
      logic    valid;
      cmt_id_t cmt_id;
   } done_rpt_t;

   // --------------------
   // Lane helpers
   // --------------------
   // Zero-extended lane at byte offset off
   function automatic logic [31:0] lane_extract(elem_word_u w, logic [1:0] off, sew_t sew);
      case (sew)
         SEW_B:   return {24'd0, w.b[off]};
         SEW_H:   return {16'd0, w.h[off[1]]};
         SEW_W:   return w.w;
         default: return w.w;
      endcase
   endfunction

   // Low sew bytes of data written into the lane at off
   function automatic elem_word_u lane_merge(elem_word_u w, logic [1:0] off, sew_t sew,
                                             logic [31:0] data);
      elem_word_u r;
      r = w;
      case (sew)
         SEW_B:   r.b[off] = data[7:0];
         SEW_H:   r.h[off[1]] = data[15:0];
         default: r.w = data;
      endcase
      return r;
   endfunction

endpackage
